/* la_wb_pkg.sv */
package la_wb_pkg;

    localparam int xlen      = 32;
    localparam int csr_num_w = 14;
    localparam int ecode_w   = 6;

    // csr numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h0;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h1;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h5;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h6;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h7;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'hc;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h30;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h31;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h32;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h33;

    // exception codes
    localparam logic [ecode_w-1:0] ecode_sys  = 6'hb;
    localparam logic [ecode_w-1:0] ecode_brk  = 6'hc;
    localparam logic [ecode_w-1:0] ecode_adef = 6'h8;
    localparam logic [ecode_w-1:0] ecode_ine  = 6'hd;
    localparam logic [ecode_w-1:0] ecode_ale  = 6'h9;

    typedef struct packed {
        logic csrrd;
        logic csrwr;
        logic csrxchg;
        logic ertn;
        logic syscall;
    } csr_op_t;

    typedef struct packed {
        logic adef;
        logic brk;
        logic ine;
        logic ale;
    } exc_op_t;

    // memory to write-back bus, 172 bits
    typedef struct packed {
        exc_op_t             exc;
        logic [xlen-1:0]     rj_value;
        logic [xlen-1:0]     rkd_value;
        csr_op_t             csr_op;
        logic [csr_num_w-1:0] csr_num;
        logic [14:0]         csr_code;
        logic                gr_we;
        logic [4:0]          dest;
        logic [xlen-1:0]     final_result;
        logic [xlen-1:0]     pc;
    } ms_to_ws_t;

    typedef struct packed {
        logic                 re;
        logic [csr_num_w-1:0] num;
        logic                 we;
        logic [xlen-1:0]      wmask;
        logic [xlen-1:0]      wvalue;
        logic                 ex;
        logic [ecode_w-1:0]   ecode;
        logic                 ertn;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      vaddr;
    } csr_req_t;

    typedef struct packed {
        logic            valid;
        logic            we;
        logic [4:0]      waddr;
        logic [xlen-1:0] wdata;
    } rf_wr_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [3:0]      rf_we;
        logic [4:0]      rf_wnum;
        logic [xlen-1:0] rf_wdata;
    } debug_trace_t;

endpackage

/* reg_file.sv */
module reg_file (
    input  logic                        clk,
    input  la_wb_pkg::rf_wr_t           rf_wr,
    input  logic [4:0]                  raddr,
    output logic [la_wb_pkg::xlen-1:0]  rdata
);
    import la_wb_pkg::*;

    logic [xlen-1:0] regs [32];
    logic            wr_en;

    // r0 is hardwired, never written
    assign wr_en = rf_wr.valid && rf_wr.we && (rf_wr.waddr != 5'd0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[rf_wr.waddr] <= rf_wr.wdata;
        end
    end

    always_comb begin
        if (raddr == 5'd0) begin
            rdata = '0;
        end else begin
            rdata = regs[raddr];
        end
    end

endmodule

/* csr_file.sv */
module csr_file (
    input  logic                        clk,
    input  logic                        reset,
    input  la_wb_pkg::csr_req_t         csr_req,
    output logic [la_wb_pkg::xlen-1:0]  csr_rvalue,
    output logic [la_wb_pkg::xlen-1:0]  csr_eentry,
    output logic [la_wb_pkg::xlen-1:0]  csr_era
);
    import la_wb_pkg::*;

    // crmd fields
    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;

    // prmd fields
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;

    logic [ecode_w-1:0] estat_ecode;
    logic [xlen-1:0]    era_q;
    logic [xlen-1:0]    badv_q;
    logic [25:0]        eentry_va;
    logic [xlen-1:0]    save_q [4];

    logic [xlen-1:0] crmd_value;
    logic [xlen-1:0] prmd_value;
    logic [xlen-1:0] estat_value;
    logic [xlen-1:0] eentry_value;
    logic [xlen-1:0] csr_value;
    logic [xlen-1:0] wmerged;
    logic            badv_hit;

    assign crmd_value   = {28'b0, crmd_da, crmd_ie, crmd_plv};
    assign prmd_value   = {29'b0, prmd_pie, prmd_pplv};
    // esubcode in bits 30..22 stays zero
    assign estat_value  = {10'b0, estat_ecode, 16'b0};
    assign eentry_value = {eentry_va, 6'b0};

    // era and eentry numbers are scoped, the ports share their names
    always_comb begin
        case (csr_req.num)
            csr_crmd:              csr_value = crmd_value;
            csr_prmd:              csr_value = prmd_value;
            csr_estat:             csr_value = estat_value;
            la_wb_pkg::csr_era:    csr_value = era_q;
            csr_badv:              csr_value = badv_q;
            la_wb_pkg::csr_eentry: csr_value = eentry_value;
            csr_save0:             csr_value = save_q[0];
            csr_save1:             csr_value = save_q[1];
            csr_save2:             csr_value = save_q[2];
            csr_save3:             csr_value = save_q[3];
            default:               csr_value = '0;
        endcase
    end

    assign csr_rvalue = csr_req.re ? csr_value : '0;

    // old value with the masked bits replaced
    assign wmerged = (csr_value & ~csr_req.wmask) | (csr_req.wvalue & csr_req.wmask);

    assign badv_hit = (csr_req.ecode == ecode_adef) || (csr_req.ecode == ecode_ale);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;
        end else if (csr_req.ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (csr_req.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_req.we && csr_req.num == csr_crmd) begin
            crmd_plv <= wmerged[1:0];
            crmd_ie  <= wmerged[2];
            crmd_da  <= wmerged[3];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (csr_req.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_req.we && csr_req.num == csr_prmd) begin
            prmd_pplv <= wmerged[1:0];
            prmd_pie  <= wmerged[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_ecode <= '0;
            era_q       <= '0;
            badv_q      <= '0;
            eentry_va   <= '0;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (csr_req.ex) begin
            estat_ecode <= csr_req.ecode;
            era_q       <= csr_req.pc;
            if (badv_hit) begin
                badv_q <= csr_req.vaddr;
            end
        end else if (csr_req.we) begin
            case (csr_req.num)
                la_wb_pkg::csr_era:    era_q     <= wmerged;
                csr_badv:              badv_q    <= wmerged;
                la_wb_pkg::csr_eentry: eentry_va <= wmerged[31:6];
                csr_save0:             save_q[0] <= wmerged;
                csr_save1:             save_q[1] <= wmerged;
                csr_save2:             save_q[2] <= wmerged;
                csr_save3:             save_q[3] <= wmerged;
                default:               ;
            endcase
        end
    end

    assign csr_eentry = eentry_value;
    assign csr_era    = era_q;

    // the stage must suppress csr writes of a faulting instruction
    assert property (@(posedge clk) disable iff (reset) !(csr_req.we && csr_req.ex))
        else $error("csr write requested together with exception entry");

endmodule

/* wb_stage.sv */
module wb_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ms_to_ws_valid,
    input  la_wb_pkg::ms_to_ws_t        ms_to_ws_bus,
    output logic                        ws_allowin,
    input  logic [la_wb_pkg::xlen-1:0]  csr_rvalue,
    output la_wb_pkg::csr_req_t         csr_req,
    output la_wb_pkg::rf_wr_t           rf_wr,
    output la_wb_pkg::debug_trace_t     debug,
    output logic                        wb_ex,
    output logic                        wb_ertn
);
    import la_wb_pkg::*;

    logic       ws_valid;
    logic       ws_ready_go;
    ms_to_ws_t  ws_bus;

    logic            csr_inst;
    logic            rf_we;
    logic [xlen-1:0] rf_wdata;

    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    // a flushed slot is refilled by whatever arrives at the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    assign wb_ex = ws_valid && (ws_bus.csr_op.syscall || ws_bus.exc.brk ||
                                ws_bus.exc.adef || ws_bus.exc.ine || ws_bus.exc.ale);
    assign wb_ertn = ws_valid && ws_bus.csr_op.ertn;

    assign csr_inst = ws_bus.csr_op.csrrd || ws_bus.csr_op.csrwr || ws_bus.csr_op.csrxchg;

    always_comb begin
        csr_req        = '0;
        csr_req.re     = ws_valid && (csr_inst || ws_bus.csr_op.ertn);
        csr_req.num    = ws_bus.csr_op.ertn ? csr_era : ws_bus.csr_num;
        csr_req.we     = ws_valid && !wb_ex &&
                         (ws_bus.csr_op.csrwr || ws_bus.csr_op.csrxchg);
        csr_req.wvalue = ws_bus.rkd_value;
        csr_req.ex     = wb_ex;
        csr_req.ertn   = wb_ertn;
        csr_req.pc     = ws_bus.pc;

        // csrxchg masks with rj
        if (ws_bus.csr_op.csrxchg) begin
            csr_req.wmask = ws_bus.rj_value;
        end else if (ws_bus.csr_op.csrwr) begin
            csr_req.wmask = '1;
        end

        // priority order of exception sources
        if (ws_bus.csr_op.syscall) begin
            csr_req.ecode = ecode_sys;
        end else if (ws_bus.exc.brk) begin
            csr_req.ecode = ecode_brk;
        end else if (ws_bus.exc.adef) begin
            csr_req.ecode = ecode_adef;
        end else if (ws_bus.exc.ine) begin
            csr_req.ecode = ecode_ine;
        end else if (ws_bus.exc.ale) begin
            csr_req.ecode = ecode_ale;
        end

        if (ws_bus.exc.adef) begin
            csr_req.vaddr = ws_bus.pc;
        end else if (ws_bus.exc.ale) begin
            csr_req.vaddr = ws_bus.final_result;
        end
    end

    assign rf_we    = ws_valid && ws_bus.gr_we && !wb_ex;
    assign rf_wdata = csr_inst ? csr_rvalue : ws_bus.final_result;

    assign rf_wr.valid = ws_valid;
    assign rf_wr.we    = rf_we;
    assign rf_wr.waddr = ws_bus.dest;
    assign rf_wr.wdata = rf_wdata;

    assign debug.pc       = ws_bus.pc;
    assign debug.rf_we    = {4{rf_we}};
    assign debug.rf_wnum  = ws_bus.dest;
    assign debug.rf_wdata = rf_wdata;

    assert property (@(posedge clk) disable iff (reset) ws_allowin)
        else $error("write-back stage stalled");

    // ertn and an exception on one instruction would fight over crmd
    assert property (@(posedge clk) disable iff (reset) !(wb_ex && wb_ertn))
        else $error("wb_ex and wb_ertn raised together");

endmodule

/* wb_subsystem.sv */
module wb_subsystem (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ms_to_ws_valid,
    input  la_wb_pkg::ms_to_ws_t        ms_to_ws_bus,
    output logic                        ws_allowin,
    output la_wb_pkg::debug_trace_t     debug,
    output logic                        wb_ex,
    output logic                        wb_ertn,
    output logic [la_wb_pkg::xlen-1:0]  csr_eentry,
    output logic [la_wb_pkg::xlen-1:0]  csr_era,
    input  logic [4:0]                  reg_raddr,
    output logic [la_wb_pkg::xlen-1:0]  reg_rdata
);
    import la_wb_pkg::*;

    csr_req_t        csr_req;
    logic [xlen-1:0] csr_rvalue;
    rf_wr_t          rf_wr;

    wb_stage wb_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .csr_rvalue     (csr_rvalue),
        .csr_req        (csr_req),
        .rf_wr          (rf_wr),
        .debug          (debug),
        .wb_ex          (wb_ex),
        .wb_ertn        (wb_ertn)
    );

    // eentry and era go straight from the csr registers to fetch
    csr_file csr_file_inst (
        .clk        (clk),
        .reset      (reset),
        .csr_req    (csr_req),
        .csr_rvalue (csr_rvalue),
        .csr_eentry (csr_eentry),
        .csr_era    (csr_era)
    );

    reg_file reg_file_inst (
        .clk   (clk),
        .rf_wr (rf_wr),
        .raddr (reg_raddr),
        .rdata (reg_rdata)
    );

endmodule

/* tb_wb_subsystem.sv */
module tb_wb_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    import la_wb_pkg::*;

    typedef struct packed {
        logic            valid;
        ms_to_ws_t       bus;
        logic [3:0]      rf_we;
        logic [xlen-1:0] wdata;
        logic            ex;
        logic            ertn;
        logic [xlen-1:0] eentry;
        logic [xlen-1:0] era;
        logic            rd_check;
        logic [xlen-1:0] rd;
    } entry_t;

    localparam logic [1:0] op_rd   = 2'd0;
    localparam logic [1:0] op_wr   = 2'd1;
    localparam logic [1:0] op_xchg = 2'd2;

    logic            clk;
    logic            reset;
    logic            ms_to_ws_valid;
    ms_to_ws_t       ms_to_ws_bus;
    logic            ws_allowin;
    debug_trace_t    debug;
    logic            wb_ex;
    logic            wb_ertn;
    logic [xlen-1:0] fetch_eentry;
    logic [xlen-1:0] fetch_era;
    logic [4:0]      reg_raddr;
    logic [xlen-1:0] reg_rdata;

    entry_t          tbl[$];
    logic            tbl_ready;
    logic [31:0]     lfsr;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] model_eentry;
    logic [xlen-1:0] model_era;

    wb_subsystem wb_subsystem_inst (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .debug          (debug),
        .wb_ex          (wb_ex),
        .wb_ertn        (wb_ertn),
        .csr_eentry     (fetch_eentry),
        .csr_era        (fetch_era),
        .reg_raddr      (reg_raddr),
        .reg_rdata      (reg_rdata)
    );

    always #20 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // ecode sits in bits 21..16, subcode zero
    function automatic logic [xlen-1:0] estat_of(input logic [ecode_w-1:0] code);
        return {10'b0, code, 16'b0};
    endfunction

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] time %0t: %s is %08h, expected %08h", $time, what, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic new_bus(output ms_to_ws_t b, input logic [4:0] dest, input logic gr_we,
                           input logic [xlen-1:0] result);
        b              = '0;
        b.pc           = next_pc;
        b.dest         = dest;
        b.gr_we        = gr_we;
        b.final_result = result;
        next_pc        = next_pc + 32'd4;
    endtask

    task automatic add_entry(input logic valid, input ms_to_ws_t b, input logic [xlen-1:0] wdata,
                             input logic ex, input logic ertn, input logic rd_check,
                             input logic [xlen-1:0] rd);
        entry_t e;
        e.valid    = valid;
        e.bus      = b;
        e.rf_we    = (valid && b.gr_we && !ex) ? 4'hf : 4'h0;
        e.wdata    = wdata;
        e.ex       = ex;
        e.ertn     = ertn;
        e.eentry   = model_eentry;
        e.era      = model_era;
        e.rd_check = rd_check;
        e.rd       = rd;
        tbl.push_back(e);
    endtask

    task automatic plain_write(input logic [4:0] dest, input logic [xlen-1:0] result);
        ms_to_ws_t b;
        new_bus(b, dest, 1'b1, result);
        add_entry(1'b1, b, result, 1'b0, 1'b0, 1'b1, (dest == 5'd0) ? 32'h0 : result);
    endtask

    task automatic csr_access(input logic [1:0] op, input logic [csr_num_w-1:0] num,
                              input logic [4:0] dest, input logic [xlen-1:0] rkd,
                              input logic [xlen-1:0] rj, input logic [xlen-1:0] old);
        ms_to_ws_t b;
        // final_result must lose against the csr value
        new_bus(b, dest, 1'b1, 32'hbadc_0de0);
        b.csr_op.csrrd   = (op == op_rd);
        b.csr_op.csrwr   = (op == op_wr);
        b.csr_op.csrxchg = (op == op_xchg);
        b.csr_num        = num;
        b.rkd_value      = rkd;
        b.rj_value       = rj;
        add_entry(1'b1, b, old, 1'b0, 1'b0, 1'b1, old);
    endtask

    // exc bits are adef, brk, ine, ale; r10 holds zero and must stay so
    task automatic raise_exc(input exc_op_t exc, input logic syscall,
                             input logic [xlen-1:0] result);
        ms_to_ws_t b;
        new_bus(b, 5'd10, 1'b1, result);
        b.exc            = exc;
        b.csr_op.syscall = syscall;
        model_era        = b.pc;
        add_entry(1'b1, b, 32'h0, 1'b1, 1'b0, 1'b1, 32'h0);
    endtask

    task automatic idle_cycle();
        ms_to_ws_t b;
        new_bus(b, 5'd0, 1'b0, 32'h0);
        add_entry(1'b0, b, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic build_table();
        ms_to_ws_t       b;
        logic [4:0]      d;
        logic [xlen-1:0] v;
        logic [xlen-1:0] bad_pc;
        next_pc      = 32'h1c00_0000;
        model_eentry = '0;
        model_era    = '0;
        for (int k = 0; k < 4; k++) begin
            v = lfsr_take(5);
            d = v[4:0];
            v = lfsr_take(32);
            plain_write(d, v);
        end
        plain_write(5'd0, 32'hdead_beef);
        new_bus(b, 5'd5, 1'b0, 32'h1111_2222);
        add_entry(1'b1, b, 32'h0, 1'b0, 1'b0, 1'b0, 32'h0);
        idle_cycle();

        csr_access(op_wr, csr_save0, 5'd10, 32'h1234_5678, 32'h0, 32'h0);
        csr_access(op_rd, csr_save0, 5'd11, 32'h0, 32'h0, 32'h1234_5678);
        csr_access(op_xchg, csr_save0, 5'd12, 32'haaaa_5555, 32'h0000_ffff, 32'h1234_5678);
        csr_access(op_rd, csr_save0, 5'd13, 32'h0, 32'h0, 32'h1234_5555);
        model_eentry = 32'h1c00_8abc & 32'hffff_ffc0;
        csr_access(op_wr, la_wb_pkg::csr_eentry, 5'd14, 32'h1c00_8abc, 32'h0, 32'h0);
        csr_access(op_rd, la_wb_pkg::csr_eentry, 5'd15, 32'h0, 32'h0, model_eentry);

        // plv 3, ie 1 before the first exception
        csr_access(op_wr, csr_crmd, 5'd16, 32'h0000_000f, 32'h0, 32'h0000_0008);
        raise_exc(4'b0000, 1'b1, 32'h3c3c_0001);
        csr_access(op_rd, csr_estat, 5'd17, 32'h0, 32'h0, estat_of(ecode_sys));
        csr_access(op_rd, csr_prmd, 5'd18, 32'h0, 32'h0, 32'h0000_0007);
        csr_access(op_rd, csr_crmd, 5'd19, 32'h0, 32'h0, 32'h0000_0008);
        raise_exc(4'b0111, 1'b0, 32'h3c3c_0002);
        csr_access(op_rd, csr_estat, 5'd17, 32'h0, 32'h0, estat_of(ecode_brk));
        raise_exc(4'b1001, 1'b0, 32'h3c3c_0003);
        bad_pc = model_era;
        csr_access(op_rd, csr_estat, 5'd17, 32'h0, 32'h0, estat_of(ecode_adef));
        csr_access(op_rd, csr_badv, 5'd18, 32'h0, 32'h0, bad_pc);
        raise_exc(4'b0010, 1'b0, 32'h3c3c_0004);
        csr_access(op_rd, csr_estat, 5'd17, 32'h0, 32'h0, estat_of(ecode_ine));
        raise_exc(4'b0001, 1'b0, 32'h1c00_4003);
        csr_access(op_rd, csr_estat, 5'd17, 32'h0, 32'h0, estat_of(ecode_ale));
        csr_access(op_rd, csr_badv, 5'd18, 32'h0, 32'h0, 32'h1c00_4003);

        // plv 2, ie 1, then trap and return
        csr_access(op_wr, csr_crmd, 5'd20, 32'h0000_0006, 32'h0, 32'h0000_0008);
        raise_exc(4'b0000, 1'b1, 32'h3c3c_0005);
        new_bus(b, 5'd0, 1'b0, 32'h0);
        b.csr_op.ertn = 1'b1;
        add_entry(1'b1, b, 32'h0, 1'b0, 1'b1, 1'b0, 32'h0);
        csr_access(op_rd, csr_crmd, 5'd21, 32'h0, 32'h0, 32'h0000_0006);
        csr_access(op_rd, csr_prmd, 5'd22, 32'h0, 32'h0, 32'h0000_0006);

        raise_exc(4'b0000, 1'b1, 32'h3c3c_0006);
        plain_write(5'd23, 32'h5a5a_0001);
        raise_exc(4'b0010, 1'b0, 32'h3c3c_0007);
        idle_cycle();
        plain_write(5'd24, 32'h0f0f_7777);
    endtask

    initial begin
        wait (tbl_ready);
        #((tbl.size() + 20) * 40);
        $display("timeout: run did not finish within %0d clock cycles", tbl.size() + 20);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        entry_t e;
        int     n;
        clk            = 1'b0;
        reset          = 1'b1;
        ms_to_ws_valid = 1'b0;
        ms_to_ws_bus   = '0;
        reg_raddr      = 5'd0;
        lfsr           = 32'ha890_0234;
        tbl_ready      = 1'b0;
        build_table();
        n         = tbl.size();
        tbl_ready = 1'b1;

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        #5;
        expect_equal("rf_we after reset", 32'(debug.rf_we), 32'h0);
        expect_equal("wb_ex after reset", 32'(wb_ex), 32'h0);
        expect_equal("wb_ertn after reset", 32'(wb_ertn), 32'h0);
        expect_equal("eentry after reset", fetch_eentry, 32'h0);
        expect_equal("era after reset", fetch_era, 32'h0);

        // entry s enters the stage one edge after it is driven and commits one edge later
        for (int s = 0; s < n + 2; s++) begin
            @(posedge clk);
            #2;
            if (s < n) begin
                ms_to_ws_valid = tbl[s].valid;
                ms_to_ws_bus   = tbl[s].bus;
            end else begin
                ms_to_ws_valid = 1'b0;
                ms_to_ws_bus   = '0;
            end
            if (s >= 2) begin
                reg_raddr = tbl[s-2].bus.dest;
            end
            #5;
            if (s >= 1 && s <= n) begin
                e = tbl[s-1];
                expect_equal("ws_allowin", 32'(ws_allowin), 32'h1);
                expect_equal("trace rf_we", 32'(debug.rf_we), 32'(e.rf_we));
                expect_equal("wb_ex", 32'(wb_ex), 32'(e.ex));
                expect_equal("wb_ertn", 32'(wb_ertn), 32'(e.ertn));
                if (e.valid) begin
                    expect_equal("trace pc", debug.pc, e.bus.pc);
                end
                if (e.rf_we != 4'h0) begin
                    expect_equal("trace rf_wnum", 32'(debug.rf_wnum), 32'(e.bus.dest));
                    expect_equal("trace rf_wdata", debug.rf_wdata, e.wdata);
                end
            end
            if (s >= 2) begin
                e = tbl[s-2];
                expect_equal("csr_eentry", fetch_eentry, e.eentry);
                expect_equal("csr_era", fetch_era, e.era);
                if (e.rd_check) begin
                    expect_equal("register readback", reg_rdata, e.rd);
                end
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* tb.f */
la_wb_pkg.sv
reg_file.sv
csr_file.sv
wb_stage.sv
wb_subsystem.sv
tb_wb_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_wb_subsystem
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard *.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) tb.f
	$(VERILATOR) $(VFLAGS) -f tb.f --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
